// File: include/px_params.svh
// Control unit parameters
`ifndef PX_PARAMS_SVH
`define PX_PARAMS_SVH

// System bus widths
`define PX_ADDR_W 16		// Bus address width
`define PX_DATA_W 16		// Bus data width

// Bus cycle timeout
`define PX_ALARM_TICKS 32	// Cycles without rok/ren before ALARM

// Interrupt phase addresses
`define PX_STACK_ADDR 16'h0061	// I1 saves ic here
`define PX_STATUS_ADDR 16'h0062	// I2 saves status here
`define PX_VECTOR_BASE 16'h0040	// I3 reads base+n

// Interrupt lines
`define PX_IRQ_N 4		// Level request inputs

`endif

// File: source/px_pkg.sv
// Control unit types
`include "px_params.svh"

package px_pkg;

	// Cycle states, as named on the state control board
	typedef enum logic [3:0] {
		S_P1     = 4'd0,	// Accept instruction
		S_K1     = 4'd1,	// Address cycle
		S_WR     = 4'd2,	// Memory read
		S_WW     = 4'd3,	// Memory write
		S_WM     = 4'd4,	// I/O transfer
		S_KC     = 4'd5,	// End of cycle
		S_I1     = 4'd6,	// Save ic
		S_I2     = 4'd7,	// Save status
		S_I3     = 4'd8,	// Read vector
		S_I4     = 4'd9,	// Vector settle
		S_I5     = 4'd10,	// Load new ic
		S_IDLE_I = 4'd11	// Abort slot of the interrupt phase
	} state_e;

	typedef enum logic [2:0] {
		OP_LW  = 3'd0,	// Load
		OP_RW  = 3'd1,	// Store
		OP_IN  = 3'd2,	// I/O input
		OP_OU  = 3'd3,	// I/O output
		OP_NOP = 3'd4
	} op_e;

	typedef enum logic [1:0] {
		BUS_READ   = 2'd0,
		BUS_WRITE  = 2'd1,
		BUS_IO_IN  = 2'd2,
		BUS_IO_OUT = 2'd3
	} bus_op_e;

	typedef enum logic [1:0] {
		STAT_OK    = 2'd0,	// Target answered
		STAT_EN    = 2'd1,	// Not available
		STAT_ALARM = 2'd2	// No answer, timed out
	} bus_stat_e;

	// Bus controller phases
	typedef enum logic [1:0] {
		PH_IDLE = 2'd0,
		PH_REQ  = 2'd1,	// zg up, waiting for zw
		PH_WAIT = 2'd2	// Strobed, waiting for answer
	} bus_ph_e;

	typedef logic [$clog2(`PX_IRQ_N)-1:0] irq_num_t;

	typedef struct packed {
		op_e                   op;
		logic [`PX_ADDR_W-1:0] addr;
		logic [`PX_DATA_W-1:0] data;
	} instr_t;

	typedef struct packed {
		bus_op_e               op;
		logic [`PX_ADDR_W-1:0] addr;
		logic [`PX_DATA_W-1:0] data;
	} bus_cmd_t;

	typedef struct packed {
		bus_stat_e             stat;
		logic [`PX_DATA_W-1:0] data;
	} bus_rsp_t;

	typedef struct packed {
		bus_op_e               op;
		logic [`PX_ADDR_W-1:0] addr;
		logic [`PX_DATA_W-1:0] data;
	} bus_cyc_t;

	typedef struct packed {
		op_e                   op;
		bus_stat_e             stat;
		logic [`PX_DATA_W-1:0] data;
		logic [`PX_ADDR_W-1:0] ic;	// Counter after the instruction
	} result_t;

	typedef struct packed {
		irq_num_t              number;
		logic [`PX_ADDR_W-1:0] ic;	// Counter to be saved in I1
	} irq_cmd_t;

endpackage

// File: source/px_bus_ctl.sv
// System bus cycle controller
`timescale 1ns/1ps
`include "px_params.svh"

module px_bus_ctl (
	input  logic                  got,
	input  logic                  clo,
	input  px_pkg::bus_cmd_t      cmd,
	input  logic                  cmd_valid,
	output logic                  cmd_ready,
	output logic                  zg,		// Bus request
	input  logic                  zw,		// Bus grant
	output px_pkg::bus_cyc_t      bus_cyc,
	output logic                  bus_strobe,
	input  logic                  rok,
	input  logic                  ren,
	input  logic [`PX_DATA_W-1:0] rdata,
	output px_pkg::bus_rsp_t      rsp,
	output logic                  rsp_valid
);
	import px_pkg::*;

	localparam int TMR_W = $clog2(`PX_ALARM_TICKS);

	bus_ph_e          ph;
	bus_cmd_t         cur;		// Command being run
	logic [TMR_W-1:0] tmr;		// Alarm down-counter
	logic             answer;	// rok/ren while waiting
	logic             timeout;

	assign cmd_ready  = (ph == PH_IDLE);
	assign bus_strobe = (ph == PH_REQ) && zw;	// First granted cycle only
	assign answer     = (ph == PH_WAIT) && (rok || ren);	// Stray answers dropped
	assign timeout    = (ph == PH_WAIT) && !answer && (tmr == '0);
	assign bus_cyc    = '{op: cur.op, addr: cur.addr, data: cur.data};

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			ph        <= PH_IDLE;
			zg        <= 1'b0;
			rsp_valid <= 1'b0;
			tmr       <= '0;
		end else begin
			rsp_valid <= answer || timeout;	// One-cycle pulse
			case (ph)
				PH_IDLE: begin
					if (cmd_valid) begin
						ph <= PH_REQ;
						zg <= 1'b1;
					end
				end
				PH_REQ: begin
					if (zw) begin
						ph  <= PH_WAIT;
						tmr <= TMR_W'(`PX_ALARM_TICKS - 1);	// Start alarm timer
					end
				end
				PH_WAIT: begin
					if (answer || timeout) begin
						ph <= PH_IDLE;
						zg <= 1'b0;	// Drops with rsp_valid
					end else begin
						tmr <= tmr - 1'b1;
					end
				end
				default: ph <= PH_IDLE;
			endcase
		end
	end

	// Command and response payload
	always_ff @(posedge got) begin
		if (cmd_valid && cmd_ready)
			cur <= cmd;
		if (answer) begin
			if (rok) begin
				rsp.stat <= STAT_OK;	// rok wins over ren
				rsp.data <= rdata;
			end else begin
				rsp.stat <= STAT_EN;
				rsp.data <= '0;
			end
		end else if (timeout) begin
			rsp.stat <= STAT_ALARM;
			rsp.data <= '0;
		end
	end

	a_zg_held: assert property (@(posedge got) disable iff (clo)
		zg && !rsp_valid |=> zg || rsp_valid);

	a_strobe_single: assert property (@(posedge got) disable iff (clo)
		bus_strobe |=> !bus_strobe);

endmodule

// File: source/px_irq_phase.sv
// Interrupt latch and phase control
`timescale 1ns/1ps
`include "px_params.svh"

module px_irq_phase (
	input  logic                 got,
	input  logic                 clo,
	input  logic [`PX_IRQ_N-1:0] irq,
	input  logic                 instr_done,
	input  logic                 irq_ready,
	input  logic                 irq_done,
	input  logic                 abort_n,	// Low for one cycle on aborted phase
	input  px_pkg::state_e       state,
	input  logic [`PX_ADDR_W-1:0] ic,
	output px_pkg::irq_cmd_t     irq_cmd,
	output logic                 irq_valid
);
	import px_pkg::*;

	logic [`PX_IRQ_N-1:0] latch;	// Latched requests
	logic [`PX_IRQ_N-1:0] clr;	// Line to drop this cycle
	logic                 busy;	// Phase I1..I5 running
	logic                 finish;	// Phase over, either way
	logic                 raise;
	irq_num_t             pick;	// Highest priority line
	irq_num_t             num;	// Line offered or served

	assign finish = busy && (irq_done || !abort_n);
	assign raise  = !irq_valid && !busy && (|latch)
		&& ((state == S_P1) || instr_done);	// Only between instructions

	// Lowest index wins
	always_comb begin
		pick = '0;
		for (int i = `PX_IRQ_N - 1; i >= 0; i--) begin
			if (latch[i])
				pick = irq_num_t'(i);
		end
	end

	always_comb begin
		clr = '0;
		if (finish)
			clr[num] = 1'b1;
	end

	assign irq_cmd = '{number: num, ic: ic};	// Live counter

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			latch     <= '0;
			busy      <= 1'b0;
			irq_valid <= 1'b0;
		end else begin
			latch <= (latch | irq) & ~clr;	// Clear wins for that cycle
			if (irq_valid && irq_ready) begin
				irq_valid <= 1'b0;
				busy      <= 1'b1;
			end else if (raise) begin
				irq_valid <= 1'b1;
			end
			if (finish)
				busy <= 1'b0;
		end
	end

	// Number frozen while offered and served
	always_ff @(posedge got) begin
		if (raise)
			num <= pick;
	end

	a_no_rise_in_phase: assert property (@(posedge got) disable iff (clo)
		$rose(irq_valid) |-> !(state inside {S_I1, S_I2, S_I3, S_I4, S_I5}));

endmodule

// File: source/px_state_seq.sv
// Instruction cycle sequencer
`timescale 1ns/1ps
`include "px_params.svh"

module px_state_seq (
	input  logic              got,
	input  logic              clo,
	input  px_pkg::instr_t    in_instr,
	input  logic              in_valid,
	output logic              in_ready,
	output px_pkg::result_t   out_result,
	output logic              out_valid,
	input  logic              out_ready,
	output px_pkg::bus_cmd_t  cmd,
	output logic              cmd_valid,
	input  logic              cmd_ready,
	input  px_pkg::bus_rsp_t  rsp,
	input  logic              rsp_valid,
	input  px_pkg::irq_cmd_t  irq_cmd,
	input  logic              irq_valid,
	output logic              irq_ready,
	output logic              instr_done,
	output logic              irq_done,
	output px_pkg::state_e    state
);
	import px_pkg::*;

	state_e                state_nx;
	logic [`PX_ADDR_W-1:0] ic;		// Instruction counter
	logic                  cmd_issued;	// Bus cycle in flight
	logic                  bus_wait;	// State needs a bus cycle
	logic                  accept;
	logic                  take_irq;
	instr_t                instr;		// Current instruction
	irq_num_t              irq_num;		// Interrupt being served
	logic [`PX_ADDR_W-1:0] save_ic;		// ic at interrupt entry
	bus_stat_e             bus_stat;	// Last bus outcome
	logic [`PX_DATA_W-1:0] bus_data;	// Last read data, also the vector
	logic                  is_load;

	assign in_ready   = (state == S_P1) && !irq_valid;	// No fetch while irq pending
	assign irq_ready  = (state == S_P1);
	assign accept     = in_valid && in_ready;
	assign take_irq   = irq_valid && irq_ready;
	assign out_valid  = (state == S_KC);
	assign instr_done = out_valid && out_ready;
	assign irq_done   = (state == S_I5);
	assign bus_wait   = state inside {S_WR, S_WW, S_WM, S_I1, S_I2, S_I3};
	assign cmd_valid  = bus_wait && !cmd_issued;
	assign is_load    = (instr.op == OP_LW) || (instr.op == OP_IN);

	assign out_result = '{op: instr.op, stat: bus_stat,
		data: is_load ? bus_data : '0, ic: ic};

	// Bus command per state
	always_comb begin
		cmd = '{op: BUS_READ, addr: instr.addr, data: instr.data};
		case (state)
			S_WW: cmd.op = BUS_WRITE;
			S_WM: cmd.op = (instr.op == OP_IN) ? BUS_IO_IN : BUS_IO_OUT;
			S_I1: cmd = '{op: BUS_WRITE, addr: `PX_STACK_ADDR, data: save_ic};
			S_I2: cmd = '{op: BUS_WRITE, addr: `PX_STATUS_ADDR,
				data: `PX_DATA_W'(irq_num)};	// Status is the irq number
			S_I3: cmd = '{op: BUS_READ,
				addr: `PX_VECTOR_BASE + `PX_ADDR_W'(irq_num), data: '0};
			default: ;
		endcase
	end

	// Enter-state logic
	always_comb begin
		state_nx = state;
		case (state)
			S_P1: begin
				if (accept)
					state_nx = S_K1;
				else if (take_irq)
					state_nx = S_I1;
			end
			S_K1: begin
				case (instr.op)
					OP_LW:   state_nx = S_WR;
					OP_RW:   state_nx = S_WW;
					OP_IN,
					OP_OU:   state_nx = S_WM;
					default: state_nx = S_KC;	// NOP skips the bus
				endcase
			end
			S_WR, S_WW, S_WM:
				if (rsp_valid) state_nx = S_KC;	// Any outcome ends the cycle
			S_KC:
				if (out_ready) state_nx = S_P1;	// Hold result until taken
			S_I1:
				if (rsp_valid) state_nx = (rsp.stat == STAT_OK) ? S_I2 : S_IDLE_I;
			S_I2:
				if (rsp_valid) state_nx = (rsp.stat == STAT_OK) ? S_I3 : S_IDLE_I;
			S_I3:
				if (rsp_valid) state_nx = (rsp.stat == STAT_OK) ? S_I4 : S_IDLE_I;
			S_I4:     state_nx = S_I5;
			S_I5:     state_nx = S_P1;
			S_IDLE_I: state_nx = S_P1;	// Abort, ic untouched
			default:  state_nx = S_P1;
		endcase
	end

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			state      <= S_P1;
			ic         <= '0;
			cmd_issued <= 1'b0;
		end else begin
			state <= state_nx;
			if (accept)
				ic <= ic + 1'b1;	// Count on accept
			else if (state == S_I5)
				ic <= bus_data;	// Jump to vector
			if (rsp_valid)
				cmd_issued <= 1'b0;
			else if (cmd_valid && cmd_ready)
				cmd_issued <= 1'b1;
		end
	end

	// Payload registers
	always_ff @(posedge got) begin
		if (accept)
			instr <= in_instr;
		if (take_irq) begin
			irq_num <= irq_cmd.number;
			save_ic <= irq_cmd.ic;
		end
		if (rsp_valid) begin
			bus_stat <= rsp.stat;
			bus_data <= rsp.data;
		end else if (state == S_K1) begin
			bus_stat <= STAT_OK;	// NOP result
		end
	end

	a_result_stable: assert property (@(posedge got) disable iff (clo)
		out_valid && !out_ready |=> $stable(out_result));

endmodule

// File: source/px_top.sv
// Control unit top level
`timescale 1ns/1ps
`include "px_params.svh"

module px_top (
	input  logic                  got,
	input  logic                  clo,
	input  px_pkg::instr_t        in_instr,
	input  logic                  in_valid,
	output logic                  in_ready,
	output px_pkg::result_t       out_result,
	output logic                  out_valid,
	input  logic                  out_ready,
	input  logic [`PX_IRQ_N-1:0]  irq,
	output logic                  zg,
	input  logic                  zw,
	output px_pkg::bus_cyc_t      bus_cyc,
	output logic                  bus_strobe,
	input  logic                  rok,
	input  logic                  ren,
	input  logic [`PX_DATA_W-1:0] rdata
);
	import px_pkg::*;

	bus_cmd_t cmd;
	logic     cmd_valid;
	logic     cmd_ready;
	bus_rsp_t rsp;
	logic     rsp_valid;
	irq_cmd_t irq_cmd;
	logic     irq_valid;
	logic     irq_ready;
	logic     instr_done;
	logic     irq_done;
	logic     abort_n;
	state_e   state;

	assign abort_n = (state != S_IDLE_I);	// Abort slot decode

	px_state_seq u_seq (
		.got, .clo,
		.in_instr, .in_valid, .in_ready,
		.out_result, .out_valid, .out_ready,
		.cmd, .cmd_valid, .cmd_ready,
		.rsp, .rsp_valid,
		.irq_cmd, .irq_valid, .irq_ready,
		.instr_done, .irq_done, .state
	);

	px_irq_phase u_irq (
		.got, .clo, .irq,
		.instr_done, .irq_ready, .irq_done, .abort_n, .state,
		.ic        (out_result.ic),	// Counter rides on the result
		.irq_cmd, .irq_valid
	);

	px_bus_ctl u_bus (
		.got, .clo,
		.cmd, .cmd_valid, .cmd_ready,
		.zg, .zw, .bus_cyc, .bus_strobe,
		.rok, .ren, .rdata,
		.rsp, .rsp_valid
	);

endmodule

// File: testbench/px_tb_model.sv
// Reference model of the bus targets
`timescale 1ns/1ps
`include "px_params.svh"

module px_tb_model;
	import px_pkg::*;

	logic [`PX_DATA_W-1:0] mem [logic [`PX_ADDR_W-1:0]];	// Written memory words
	logic [`PX_DATA_W-1:0] io  [logic [`PX_ADDR_W-1:0]];	// Written I/O ports
	logic [`PX_ADDR_W-1:0] ic;	// Expected instruction counter

	initial ic = '0;

	// Outcome by address class
	function automatic bus_stat_e stat_of(input logic [`PX_ADDR_W-1:0] addr);
		if (addr[`PX_ADDR_W-1])
			return STAT_EN;
		if (addr[15:8] == 8'h7F)
			return STAT_ALARM;	// Target never answers
		return STAT_OK;
	endfunction

	function automatic logic [`PX_DATA_W-1:0] mem_read(input logic [`PX_ADDR_W-1:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return (addr * 16'h9e37) ^ {addr[7:0], addr[15:8]} ^ 16'hc35a;	// Fill uses all bits
	endfunction

	function automatic logic [`PX_DATA_W-1:0] io_read(input logic [`PX_ADDR_W-1:0] addr);
		if (io.exists(addr))
			return io[addr];
		return ~(addr * 16'h2f1b) ^ {addr[3:0], addr[15:4]};
	endfunction

	task automatic mem_write(input logic [`PX_ADDR_W-1:0] addr, input logic [`PX_DATA_W-1:0] d);
		mem[addr] = d;
	endtask

	task automatic io_write(input logic [`PX_ADDR_W-1:0] addr, input logic [`PX_DATA_W-1:0] d);
		io[addr] = d;
	endtask

	task automatic set_ic(input logic [`PX_ADDR_W-1:0] v);
		ic = v;	// Interrupt jump
	endtask

	// Expected result, taken at the accept edge
	function automatic result_t predict(input instr_t i);
		result_t   r;
		bus_stat_e s;
		ic = ic + 1'b1;
		s = (i.op == OP_NOP) ? STAT_OK : stat_of(i.addr);
		r.op   = i.op;
		r.stat = s;
		r.ic   = ic;
		r.data = '0;
		if (s == STAT_OK && i.op == OP_LW)
			r.data = mem_read(i.addr);
		if (s == STAT_OK && i.op == OP_IN)
			r.data = io_read(i.addr);
		return r;
	endfunction

endmodule

// File: testbench/px_tb.sv
// Control unit testbench
`timescale 1ns/1ps
`include "px_params.svh"

module px_tb;
	import px_pkg::*;

	localparam int N_TESTS = 5;

	logic got, clo, in_valid, in_ready, out_valid, out_ready;
	logic zg, zw, bus_strobe, rok, ren;
	logic [`PX_IRQ_N-1:0]  irq;
	logic [`PX_DATA_W-1:0] rdata;
	instr_t   in_instr;
	result_t  out_result;
	bus_cyc_t bus_cyc;
	bus_cyc_t bus_log [$];	// Cycles seen by the target
	logic [31:0] lfsr = 32'h8a79;
	int checks = 0;
	int errors = 0;
	int err_start;

	px_top u_px_top (.*);
	px_tb_model u_model ();

	always #50 got = ~got;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];	// Taps 32,22,2,1
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [15:0] ok_addr();
		logic [15:0] a;
		a = {1'b0, 15'(rand_bits(15))};
		if (a[15:8] == 8'h7F)
			a[8] = 1'b0;	// Keep out of the alarm page
		return a;
	endfunction

	function automatic instr_t rand_instr(input logic [15:0] addr, input bit no_nop);
		instr_t i;
		i.op   = op_e'(rand_bits(3) % (no_nop ? 4 : 5));
		i.addr = addr;
		i.data = rand_bits(16);
		return i;
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (exp === act) else begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Bus target, one cycle per request
	task automatic serve_bus();
		bus_cyc_t  c;
		bus_stat_e s;
		repeat (rand_bits(2)) @(posedge got);	// Grant delay 0-3
		#5 zw = 1'b1;
		@(posedge got);
		check_val("bus_strobe", 1, bus_strobe);
		c = bus_cyc;
		bus_log.push_back(c);
		#5 zw = 1'b0;
		s = u_model.stat_of(c.addr);
		if (s == STAT_OK) begin
			if (c.op == BUS_WRITE)
				u_model.mem_write(c.addr, c.data);
			if (c.op == BUS_IO_OUT)
				u_model.io_write(c.addr, c.data);
		end
		@(posedge got);
		check_val("bus_strobe", 0, bus_strobe);	// Single pulse
		repeat (rand_bits(3) % 6) @(posedge got);	// Answer delay 1-6
		if (s != STAT_ALARM) begin
			#5;
			rok   = (s == STAT_OK);
			ren   = (s == STAT_EN);
			rdata = (c.op == BUS_IO_IN) ? u_model.io_read(c.addr) : u_model.mem_read(c.addr);
			@(posedge got);
			#5 rok = 1'b0;
			ren = 1'b0;
		end
		while (zg) @(posedge got);
	endtask

	always begin
		@(posedge got);
		if (!clo && zg)
			serve_bus();
	end

	task automatic run_instr(input instr_t i, input int stall);
		result_t exp, first;
		bit      seen, done;
		int      held;
		seen = 0;
		done = 0;
		held = 0;
		@(posedge got);
		#5 in_instr = i;
		in_valid = 1'b1;
		do @(posedge got); while (!in_ready);	// Accept edge
		exp = u_model.predict(i);
		#5 in_valid = 1'b0;
		out_ready = (stall == 0);
		while (!done) begin
			@(posedge got);
			if (out_valid) begin
				if (!seen)
					first = out_result;
				seen = 1;
				check_val("out_result", first, out_result);
				check_val("in_ready", 0, in_ready);
				if (out_ready) begin
					done = 1;
				end else if (++held >= stall) begin
					#5 out_ready = 1'b1;
				end
			end
		end
		check_val("out_result.op", exp.op, out_result.op);
		check_val("out_result.stat", exp.stat, out_result.stat);
		check_val("out_result.data", exp.data, out_result.data);
		check_val("out_result.ic", exp.ic, out_result.ic);
	endtask

	// Pulse lines, then follow each phase in priority order
	task automatic run_irq(input logic [`PX_IRQ_N-1:0] mask);
		logic [15:0] vec;
		bus_log.delete();
		@(posedge got);
		#5 irq = mask;
		@(posedge got);
		#5 irq = '0;
		for (int n = 0; n < `PX_IRQ_N; n++) begin
			if (mask[n]) begin
				do @(posedge got); while (!u_px_top.u_seq.irq_done);
				if (bus_log.size() < 3) begin
					$display("Interrupt %0d finished without its three bus cycles", n);
					errors++;
				end else begin
					vec = `PX_VECTOR_BASE + n;
					check_val("bus_cyc.op", BUS_WRITE, bus_log[0].op);
					check_val("bus_cyc.addr", `PX_STACK_ADDR, bus_log[0].addr);
					check_val("bus_cyc.data", u_model.ic, bus_log[0].data);
					check_val("bus_cyc.op", BUS_WRITE, bus_log[1].op);
					check_val("bus_cyc.addr", `PX_STATUS_ADDR, bus_log[1].addr);
					check_val("bus_cyc.data", n, bus_log[1].data);
					check_val("bus_cyc.op", BUS_READ, bus_log[2].op);
					check_val("bus_cyc.addr", vec, bus_log[2].addr);
					u_model.set_ic(u_model.mem_read(vec));
					repeat (3) void'(bus_log.pop_front());
				end
			end
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d %s: %s, %0d errors", num, name,
			(errors == err_start) ? "ok" : "fail", errors - err_start);
		err_start = errors;
	endtask

	initial begin
		repeat (N_TESTS * 2000) @(posedge got);
		$display("Run timed out, the DUT stopped answering");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [15:0] a;
		logic [3:0]  m;
		int          b0;
		int          b1;
		got = 0;
		clo = 1;
		in_valid = 0;
		in_instr = '0;
		out_ready = 1;
		irq = '0;
		zw = 0;
		rok = 0;
		ren = 0;
		rdata = '0;
		repeat (10) @(posedge got);
		#5 clo = 0;
		err_start = 0;
		check_val("in_ready", 1, in_ready);	// Idle state after reset
		check_val("out_valid", 0, out_valid);
		check_val("zg", 0, zg);
		check_val("bus_strobe", 0, bus_strobe);
		check_val("out_result.ic", 0, out_result.ic);
		repeat (20) run_instr(rand_instr(ok_addr(), 0), 0);
		for (int k = 0; k < 4; k++) begin
			a = ok_addr();
			run_instr('{op: OP_RW, addr: a, data: rand_bits(16)}, 0);
			run_instr('{op: OP_LW, addr: a, data: '0}, 0);	// Read back
		end
		end_test(1, "loads and stores");
		repeat (8) run_instr(rand_instr({1'b1, 15'(rand_bits(15))}, 1), 0);
		repeat (2) run_instr(rand_instr(ok_addr(), 0), 0);
		end_test(2, "not available");
		repeat (4) run_instr(rand_instr({8'h7F, 8'(rand_bits(8))}, 1), 0);
		run_instr(rand_instr(ok_addr(), 0), 0);
		end_test(3, "timeout");
		repeat (15) run_instr(rand_instr(ok_addr(), 0), rand_bits(3));
		end_test(4, "back-pressure");
		run_irq(4'b1 << rand_bits(2));
		run_instr(rand_instr(ok_addr(), 0), 0);
		b0 = rand_bits(2);
		b1 = (b0 + 1 + rand_bits(2) % 3) % 4;	// Second line differs
		m  = (4'b1 << b0) | (4'b1 << b1);
		run_irq(m);
		run_instr(rand_instr(ok_addr(), 0), 0);
		end_test(5, "interrupts");
		$display("Tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: px_top.f
+incdir+include
source/px_pkg.sv
source/px_bus_ctl.sv
source/px_irq_phase.sv
source/px_state_seq.sv
source/px_top.sv
testbench/px_tb_model.sv
testbench/px_tb.sv
